// File: flist.f
hdl/robots_pkg.sv
hdl/cmd_latch.sv
hdl/scan_counter.sv
hdl/scan_sequencer.sv
hdl/field_filler.sv
hdl/dump_encoder.sv
hdl/robots_play_top.sv
tb/tile_map_model.sv
tb/tb_robots_play.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_robots_play -f flist.f
	@out="$$(./obj_dir/Vtb_robots_play)"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

// File: tb/tb_robots_play.sv
// testbench top that runs boot, refill, dump and quit scenarios on the playfield engine DUT
`timescale 1ns/100ps

module tb_robots_play;

    import robots_pkg::*;

    localparam int MEM_SIZE = 6144;
    localparam int PLAY_BYTES = 5760;
    localparam int DUMP_BYTES = 6144 + 98;
    // one unstalled pass, five cycles per position
    localparam int PASS_CYCLES = 6144 * 5;
    // eight passes with room for back-pressure
    localparam int CYCLE_LIMIT = 8 * PASS_CYCLES * 9;
    localparam int PULSE_LEVEL = 0;
    localparam int PULSE_QUIT = 1;
    localparam int PULSE_DUMP = 2;
    localparam int PULSE_CLEAR = 3;

    logic clk;
    logic rst;
    logic cmd_new_level;
    logic cmd_quit;
    logic dump_start;
    logic dump_pause;
    logic log_clr;
    tm_adr_t tm_adr;
    tm_byte_t tm_wrt;
    logic tm_wen;
    tm_byte_t tm_red;
    tm_byte_t ser_tx_dat;
    logic ser_tx_stb;
    logic ser_tx_rdy;

    tm_byte_t score_ref [0:MEM_SIZE-1];
    tm_byte_t exp_dump [0:DUMP_BYTES-1];
    int exp_len = 0;
    int rx_idx = 0;
    int dump_writes = 0;
    int cycle_cnt = 0;
    int err_cnt = 0;
    int test_errs = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int robots_a;
    int robots_b;
    time dump_time = 0;
    time quit_time = 0;
    string cur_test;

    robots_play_top UUT (.*);

    tile_map_model u_model (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles, the engine never finished the tests", cycle_cnt);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
            err_cnt++;
        end
    endtask

    // data byte of one tile map byte as the dump sends it
    function automatic tm_byte_t dump_data(input int x, input tm_byte_t b);
        if (x >= 120 && b[7]) begin
            return 8'd64 + {2'b00, b[6:5], b[3:0]};
        end
        return 8'd48 + {4'h0, b[3:0]};
    endfunction

    // whole dump stream from the model memory starting at the top right
    function automatic int build_expected_dump();
        int n;
        n = 0;
        exp_dump[n] = 8'd35;
        n++;
        for (int y = 47; y >= 0; y--) begin
            exp_dump[n] = 8'd36;
            n++;
            for (int x = 127; x >= 0; x--) begin
                exp_dump[n] = dump_data(x, u_model.mem[y * 128 + x]);
                n++;
            end
            exp_dump[n] = 8'd37;
            n++;
        end
        exp_dump[n] = 8'd38;
        n++;
        return n;
    endfunction

    // compare each strobed byte against the stream built when the first byte goes out
    always @(posedge clk) begin
        if (ser_tx_stb) begin
            if (rx_idx == 0) begin
                exp_len = build_expected_dump();
                dump_writes = u_model.wr_total;
                dump_time = $time;
            end
            if (rx_idx < exp_len) begin
                check_value({cur_test, " byte"}, int'(exp_dump[rx_idx]), int'(ser_tx_dat));
            end else begin
                $display("%s: the dump sent more bytes than the stream holds", cur_test);
                err_cnt++;
            end
            rx_idx++;
        end
    end

    task automatic pulse_input(input int which);
        @(posedge clk);
        #1;
        case (which)
            PULSE_LEVEL: cmd_new_level = 1'b1;
            PULSE_QUIT: cmd_quit = 1'b1;
            PULSE_DUMP: dump_start = 1'b1;
            default: log_clr = 1'b1;
        endcase
        @(posedge clk);
        #1;
        cmd_new_level = 1'b0;
        cmd_quit = 1'b0;
        dump_start = 1'b0;
        log_clr = 1'b0;
    endtask

    // wait for the engine to leave idle and come back to it
    task automatic wait_engine_idle();
        @(posedge clk);
        while (UUT.u_scan_sequencer.opcode == OP_IDLE) @(posedge clk);
        while (UUT.u_scan_sequencer.opcode != OP_IDLE) @(posedge clk);
        #1;
    endtask

    // every play byte written as often as expected, one player, scoreboard untouched
    task automatic check_fill(input int passes, output int robots);
        int bad;
        int players;
        int player_row;
        logic [1:0] cell_v;
        bad = 0;
        players = 0;
        player_row = 0;
        robots = 0;
        for (int a = 0; a < MEM_SIZE; a++) begin
            if (a % 128 < 120) begin
                if (u_model.wr_count[a] != passes || u_model.mem[a][7:4] != 4'h0) begin
                    bad++;
                end
                // upper cell is the even cell row
                for (int c = 0; c < 2; c++) begin
                    cell_v = u_model.mem[a][2 * c +: 2];
                    if (cell_v == 2'd1) begin
                        robots++;
                    end else if (cell_v == 2'd3) begin
                        players++;
                        player_row = 2 * (a / 128) + c;
                    end
                end
            end else if (u_model.mem[a] != score_ref[a]) begin
                bad++;
            end
        end
        check_value({cur_test, " bad bytes"}, 0, bad);
        check_value({cur_test, " writes"}, passes * PLAY_BYTES, u_model.wr_total);
        check_value({cur_test, " high nibble writes"}, 0, u_model.hi_bad);
        check_value({cur_test, " players"}, 1, players);
        check_value({cur_test, " player row"}, 1, int'(player_row >= 16 && player_row <= 79));
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errs = err_cnt;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == test_errs) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed", cur_test);
        end
    endtask

    initial begin
        rst = 1'b1;
        cmd_new_level = 1'b0;
        cmd_quit = 1'b0;
        dump_start = 1'b0;
        dump_pause = 1'b0;
        log_clr = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int a = 0; a < MEM_SIZE; a++) begin
            score_ref[a] = u_model.mem[a];
        end

        start_test("reset");
        check_value({cur_test, " tm_wen"}, 0, int'(tm_wen));
        check_value({cur_test, " ser_tx_stb"}, 0, int'(ser_tx_stb));
        end_test();

        // boot runs an empty new game pass, then the fill
        start_test("boot fill");
        wait_engine_idle();
        check_fill(1, robots_a);
        check_value({cur_test, " dump bytes"}, 0, u_model.rx_cnt);
        end_test();

        start_test("boot level");
        check_value({cur_test, " robot range"}, 1, int'(robots_a >= 5 && robots_a <= 90));
        end_test();

        start_test("new level");
        pulse_input(PULSE_CLEAR);
        pulse_input(PULSE_LEVEL);
        wait_engine_idle();
        check_fill(1, robots_b);
        check_value({cur_test, " robots rise"}, 1, int'(robots_b > robots_a && robots_b <= 150));
        end_test();

        start_test("dump");
        pulse_input(PULSE_CLEAR);
        rx_idx = 0;
        pulse_input(PULSE_DUMP);
        // pause the sink partway through the stream
        while (u_model.rx_cnt < 2000) @(posedge clk);
        #1;
        dump_pause = 1'b1;
        repeat (300) @(posedge clk);
        #1;
        dump_pause = 1'b0;
        wait_engine_idle();
        check_value({cur_test, " bytes"}, DUMP_BYTES, u_model.rx_cnt);
        check_value({cur_test, " writes"}, 0, u_model.wr_total);
        end_test();

        // quit and dump wait for the fill, then new game, new level, dump
        start_test("quit during fill");
        pulse_input(PULSE_CLEAR);
        rx_idx = 0;
        pulse_input(PULSE_LEVEL);
        while (u_model.wr_total < 1000) @(posedge clk);
        pulse_input(PULSE_QUIT);
        quit_time = $time;
        pulse_input(PULSE_DUMP);
        while (u_model.rx_cnt < DUMP_BYTES) @(posedge clk);
        repeat (20) @(posedge clk);
        #1;
        check_fill(2, robots_b);
        check_value({cur_test, " writes before dump"}, 2 * PLAY_BYTES, dump_writes);
        // the empty new game pass and the fill both run before the dump, 4 ns per cycle
        check_value({cur_test, " new game passes before dump"}, 1,
                    int'(dump_time - quit_time >= 2 * PASS_CYCLES * 4));
        check_value({cur_test, " bytes"}, DUMP_BYTES, u_model.rx_cnt);
        end_test();

        $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// File: tb/tile_map_model.sv
// tile map RAM and serial sink models for the playfield testbench, logging writes and received bytes
`timescale 1ns/100ps

module tile_map_model (
    input  logic clk,
    input  logic log_clr,
    // tile map port, read data one cycle after the address
    input  logic [12:0] tm_adr,
    input  logic [7:0] tm_wrt,
    input  logic tm_wen,
    output logic [7:0] tm_red,
    // serial sink with random ready gaps
    input  logic ser_tx_stb,
    output logic ser_tx_rdy
);

    localparam int MEM_SIZE = 6144;

    logic [7:0] mem [0:MEM_SIZE-1];
    int wr_count [0:MEM_SIZE-1];
    int wr_total;
    int hi_bad;
    int rx_cnt;
    integer seed;
    int gap;
    logic [12:0] adr_s;
    logic [7:0] wrt_s;
    logic wen_s;
    logic stb_s;
    logic clr_s;

    initial begin
        seed = 32'h73de_9fe5;
        gap = 0;
        wr_total = 0;
        hi_bad = 0;
        rx_cnt = 0;
        // every byte tied to its full address, some scoreboard bytes get bit 7
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem[a] = 8'((a * 13) ^ (a >> 6));
            wr_count[a] = 0;
        end
        tm_red = 8'h00;
        ser_tx_rdy = 1'b1;
        forever begin
            // sample the DUT at the edge, answer 1 ns later
            @(posedge clk);
            adr_s = tm_adr;
            wrt_s = tm_wrt;
            wen_s = tm_wen;
            stb_s = ser_tx_stb;
            clr_s = log_clr;
            #1;
            // read before write, old byte at last cycle's address
            tm_red = (int'(adr_s) < MEM_SIZE) ? mem[adr_s] : 8'h00;
            if (clr_s) begin
                for (int a = 0; a < MEM_SIZE; a++) begin
                    wr_count[a] = 0;
                end
                wr_total = 0;
                hi_bad = 0;
                rx_cnt = 0;
            end
            if (wen_s) begin
                // out of range writes still show up in the total
                wr_total++;
                if (int'(adr_s) < MEM_SIZE) begin
                    mem[adr_s] = wrt_s;
                    wr_count[adr_s]++;
                end
                if (wrt_s[7:4] != 4'h0) begin
                    hi_bad++;
                end
            end
            if (stb_s) begin
                rx_cnt++;
                gap = int'($unsigned($random(seed)) % 32'd8);
            end
            // ready low for the drawn number of cycles
            if (gap != 0) begin
                ser_tx_rdy = 1'b0;
                gap--;
            end else begin
                ser_tx_rdy = 1'b1;
            end
        end
    end

endmodule

// File: hdl/robots_play_top.sv
// playfield engine top level joining command latch, scan, sequencer, filler and dump
`timescale 1ns/100ps

module robots_play_top (
    input  logic clk,
    input  logic rst,
    // user commands
    input  logic cmd_new_level,
    input  logic cmd_quit,
    input  logic dump_start,
    input  logic dump_pause,
    // tile map memory
    output robots_pkg::tm_adr_t tm_adr,
    output robots_pkg::tm_byte_t tm_wrt,
    output logic tm_wen,
    input  robots_pkg::tm_byte_t tm_red,
    // serial transmitter
    output robots_pkg::tm_byte_t ser_tx_dat,
    output logic ser_tx_stb,
    input  logic ser_tx_rdy
);

    import robots_pkg::*;

    logic pend_new_level;
    logic pend_quit;
    logic pend_dump;
    logic take_new_level;
    logic take_quit;
    logic take_dump;
    logic [6:0] pos_x;
    logic [5:0] pos_y;
    phase_t phase;
    logic field_area;
    logic pass_first;
    logic pass_done;
    logic scan_run;
    logic scan_stall;
    logic level_up;
    logic game_reset;
    logic dump_active;
    logic dump_hold;
    tm_byte_t fill_byte;

    cmd_latch u_cmd_latch (.*);

    scan_counter u_scan_counter (.*);

    scan_sequencer u_scan_sequencer (.*);

    field_filler u_field_filler (.*);

    dump_encoder u_dump_encoder (.*);

endmodule

// File: hdl/dump_encoder.sv
// encodes scan positions and read bytes into the serial dump and holds the scan on back-pressure
`timescale 1ns/100ps

module dump_encoder (
    input  logic clk,
    input  logic rst,
    input  logic dump_active,
    input  logic dump_pause,
    input  logic [6:0] pos_x,
    input  logic [5:0] pos_y,
    input  robots_pkg::phase_t phase,
    input  logic field_area,
    input  robots_pkg::tm_byte_t tm_red,
    input  logic ser_tx_rdy,
    output robots_pkg::tm_byte_t ser_tx_dat,
    output logic ser_tx_stb,
    output logic dump_hold
);

    import robots_pkg::*;

    logic pass_top;
    logic row_left;
    logic row_right;
    logic want_tx;
    logic can_tx;

    // scan runs right to left, top to bottom
    assign row_right = (pos_x == 7'd127);
    assign row_left = (pos_x == 7'd0);
    assign pass_top = row_right && (pos_y == 6'd47);

    always_comb begin
        want_tx = 1'b0;
        ser_tx_dat = 8'd0;
        if ((phase == 3'd0) && pass_top) begin
            want_tx = 1'b1;
            ser_tx_dat = DUMP_START;
        end else if ((phase == 3'd1) && row_right) begin
            want_tx = 1'b1;
            ser_tx_dat = DUMP_ROW_START;
        end else if (phase == 3'd2) begin
            // address unchanged since phase 0, so tm_red holds this byte
            want_tx = 1'b1;
            if (!field_area && tm_red[7]) begin
                // tagged scoreboard byte in 64..127
                ser_tx_dat = {2'b01, tm_red[6:5], tm_red[3:0]};
            end else begin
                // cells or plain scoreboard nibble in 48..63
                ser_tx_dat = {4'h3, tm_red[3:0]};
            end
        end else if ((phase == 3'd3) && row_left) begin
            want_tx = 1'b1;
            ser_tx_dat = DUMP_ROW_END;
        end else if ((phase == 3'd4) && row_left && (pos_y == 6'd0)) begin
            want_tx = 1'b1;
            ser_tx_dat = DUMP_END;
        end
    end

    assign can_tx = ser_tx_rdy && !dump_pause;
    assign ser_tx_stb = dump_active && want_tx && can_tx;
    // stay in this phase until the byte goes out
    assign dump_hold = dump_active && want_tx && !can_tx;

    // a byte goes out only on ready, and the scan moves on right after
    stb_then_advance: assert property (
        @(posedge clk) disable iff (rst)
        ser_tx_stb |-> ser_tx_rdy ##1 (phase != $past(phase))
    );

endmodule

// File: hdl/field_filler.sv
// pseudorandom robot and player placement producing the bytes of a new level
`timescale 1ns/100ps

module field_filler (
    input  logic clk,
    input  logic rst,
    input  logic level_up,
    input  logic game_reset,
    input  logic [6:0] pos_x,
    input  logic [5:0] pos_y,
    input  robots_pkg::phase_t phase,
    output robots_pkg::tm_byte_t fill_byte
);

    import robots_pkg::*;

    // eight steps of x^29 + x^27 + 1 per clock
    function automatic logic [28:0] lfsr_step8(input logic [28:0] s);
        logic [28:0] v;
        v = s;
        for (int i = 0; i < 8; i++) begin
            v = {v[27:0], v[28] ^ v[26]};
        end
        return v;
    endfunction

    logic [28:0] prng_st;
    logic [11:0] robot_prob;
    logic place_robot;
    logic place_robot_upper;
    logic [6:0] player_x;
    logic [6:0] player_y;
    logic [6:0] new_player_x;
    logic [6:0] new_player_y;
    logic player_pair;
    cell_t upper_cell;
    cell_t lower_cell;

    // free running, never stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            prng_st <= PRNG_SEED;
        end else begin
            prng_st <= lfsr_step8(prng_st);
        end
    end

    // robot density per 65536 cells
    // bit 11 dropped before the add so it never wraps to zero
    always_ff @(posedge clk) begin
        if (rst || game_reset) begin
            robot_prob <= 12'd0;
        end else if (level_up) begin
            robot_prob <= {1'b0, robot_prob[10:0]} + ROBOT_PROB_STEP;
        end
    end

    assign place_robot = (prng_st[15:0] < {4'd0, robot_prob});

    // upper cell decided in phase 0, kept until the write in phase 3
    always_ff @(posedge clk) begin
        if (rst) begin
            place_robot_upper <= 1'b0;
        end else if (phase == 3'd0) begin
            place_robot_upper <= place_robot;
        end
    end

    // column out of the scoreboard, else the middle column 60
    assign new_player_x = (prng_st[12:6] < PLAYER_X_LIMIT) ? prng_st[12:6] : 7'd60;
    // cell row 16..79
    assign new_player_y = {1'b0, prng_st[5:0]} + PLAYER_Y_BASE;

    always_ff @(posedge clk) begin
        if (rst) begin
            player_x <= 7'd0;
            player_y <= 7'd0;
        end else if (level_up) begin
            player_x <= new_player_x;
            player_y <= new_player_y;
        end
    end

    // player row is in cells, the scan walks cell pairs
    assign player_pair = (pos_x == player_x) && (pos_y == player_y[6:1]);

    // player overrides a robot in its cell
    always_comb begin
        upper_cell = place_robot_upper ? CELL_ROBOT : CELL_EMPTY;
        lower_cell = place_robot ? CELL_ROBOT : CELL_EMPTY;
        if (player_pair && !player_y[0]) begin
            upper_cell = CELL_PLAYER;
        end
        if (player_pair && player_y[0]) begin
            lower_cell = CELL_PLAYER;
        end
    end

    // scratch nibble cleared on every fill
    assign fill_byte = {4'h0, lower_cell, upper_cell};

endmodule

// File: hdl/scan_sequencer.sv
// opcode state machine that takes pending commands and drives the tile map port
`timescale 1ns/100ps

module scan_sequencer (
    input  logic clk,
    input  logic rst,
    // pending commands and their acknowledges
    input  logic pend_new_level,
    input  logic pend_quit,
    input  logic pend_dump,
    output logic take_new_level,
    output logic take_quit,
    output logic take_dump,
    // scan position
    input  logic [6:0] pos_x,
    input  logic [5:0] pos_y,
    input  robots_pkg::phase_t phase,
    input  logic field_area,
    input  logic pass_first,
    input  logic pass_done,
    // new level contents
    input  robots_pkg::tm_byte_t fill_byte,
    // dump back-pressure
    input  logic dump_hold,
    output logic scan_run,
    output logic scan_stall,
    output logic level_up,
    output logic game_reset,
    output logic dump_active,
    // tile map port
    output robots_pkg::tm_adr_t tm_adr,
    output robots_pkg::tm_byte_t tm_wrt,
    output logic tm_wen
);

    import robots_pkg::*;

    opcode_t opcode;
    logic is_idle;
    logic pass_end;

    assign is_idle = (opcode == OP_IDLE);

    // priority: new level, quit, dump
    assign take_new_level = is_idle && pend_new_level;
    assign take_quit = is_idle && !pend_new_level && pend_quit;
    assign take_dump = is_idle && !pend_new_level && !pend_quit && pend_dump;

    // idle and boot leave the scan parked at the top right
    assign scan_run = (opcode == OP_DUMP) || (opcode == OP_NEWGAME) ||
                      (opcode == OP_NEWLEVEL);
    assign dump_active = (opcode == OP_DUMP);
    // only the dump ever holds the scan
    assign scan_stall = dump_active && dump_hold;
    assign pass_end = scan_run && !scan_stall && pass_done;

    // boot starts a game just like quit
    assign game_reset = (opcode == OP_BOOT) || take_quit;
    // a new game enters level one at the start of its empty pass
    assign level_up = take_new_level || ((opcode == OP_NEWGAME) && pass_first);

    always_ff @(posedge clk) begin
        if (rst) begin
            opcode <= OP_BOOT;
        end else begin
            case (opcode)
                OP_BOOT: begin
                    opcode <= OP_NEWGAME;
                end
                OP_IDLE: begin
                    if (take_new_level) begin
                        opcode <= OP_NEWLEVEL;
                    end else if (take_quit) begin
                        opcode <= OP_NEWGAME;
                    end else if (take_dump) begin
                        opcode <= OP_DUMP;
                    end
                end
                OP_NEWGAME: begin
                    // the new game pass writes nothing, the fill follows
                    if (pass_end) begin
                        opcode <= OP_NEWLEVEL;
                    end
                end
                default: begin
                    if (pass_end) begin
                        opcode <= OP_IDLE;
                    end
                end
            endcase
        end
    end

    // always address the current position, dump reads it in phase 0
    assign tm_adr = {pos_y, pos_x};
    assign tm_wrt = fill_byte;
    // fill writes once per play area position, in phase 3
    assign tm_wen = (opcode == OP_NEWLEVEL) && field_area && (phase == 3'd3);

    // scoreboard columns are never written
    no_score_write: assert property (
        @(posedge clk) disable iff (rst)
        tm_wen |-> (tm_adr[6:0] < SCORE_COL_FIRST)
    );

endmodule

// File: hdl/scan_counter.sv
// scan timer walking phases, columns and rows of the tile map in reverse address order
`timescale 1ns/100ps

module scan_counter (
    input  logic clk,
    input  logic rst,
    input  logic scan_run,
    input  logic scan_stall,
    output logic [6:0] pos_x,
    output logic [5:0] pos_y,
    output robots_pkg::phase_t phase,
    output logic field_area,
    output logic pass_first,
    output logic pass_done
);

    import robots_pkg::*;

    localparam logic [6:0] COL_LAST = 7'(FIELD_COLS - 8'd1);
    localparam logic [5:0] ROW_LAST = FIELD_ROWS - 6'd1;

    logic step;
    logic last_phase;

    assign step = scan_run && !scan_stall;
    assign last_phase = (phase == PHASES - 3'd1);

    // phase fastest, then columns down, then rows down
    always_ff @(posedge clk) begin
        if (rst) begin
            pos_x <= COL_LAST;
            pos_y <= ROW_LAST;
            phase <= 3'd0;
        end else if (step) begin
            if (!last_phase) begin
                phase <= phase + 3'd1;
            end else begin
                phase <= 3'd0;
                if (pos_x != 7'd0) begin
                    pos_x <= pos_x - 7'd1;
                end else begin
                    // row finished, back to the right edge
                    pos_x <= COL_LAST;
                    // wraps to the top right when the pass ends
                    pos_y <= (pos_y != 6'd0) ? pos_y - 6'd1 : ROW_LAST;
                end
            end
        end
    end

    // scoreboard sits on the right side
    assign field_area = (pos_x < SCORE_COL_FIRST);
    assign pass_first = (pos_x == COL_LAST) && (pos_y == ROW_LAST) && (phase == 3'd0);
    assign pass_done = (pos_x == 7'd0) && (pos_y == 6'd0) && last_phase;

    phase_in_range: assert property (
        @(posedge clk) disable iff (rst)
        phase < PHASES
    );

endmodule

// File: hdl/cmd_latch.sv
// keeps pulsed user commands pending until the sequencer takes them while idle
`timescale 1ns/100ps

module cmd_latch (
    input  logic clk,
    input  logic rst,
    // one-cycle command pulses
    input  logic cmd_new_level,
    input  logic cmd_quit,
    input  logic dump_start,
    // one-cycle acknowledges from the sequencer
    input  logic take_new_level,
    input  logic take_quit,
    input  logic take_dump,
    output logic pend_new_level,
    output logic pend_quit,
    output logic pend_dump
);

    // a fresh pulse wins over a take in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            pend_new_level <= 1'b0;
            pend_quit <= 1'b0;
            pend_dump <= 1'b0;
        end else begin
            pend_new_level <= (pend_new_level & ~take_new_level) | cmd_new_level;
            pend_quit <= (pend_quit & ~take_quit) | cmd_quit;
            pend_dump <= (pend_dump & ~take_dump) | dump_start;
        end
    end

    // the sequencer only acknowledges what is actually pending
    take_only_pending: assert property (
        @(posedge clk) disable iff (rst)
        (take_new_level | take_quit | take_dump) |->
            ((take_new_level -> pend_new_level) &&
             (take_quit -> pend_quit) &&
             (take_dump -> pend_dump))
    );

endmodule

// File: hdl/robots_pkg.sv
// shared sizes, opcodes, cell codes and dump markers, imported by the playfield engine RTL
package robots_pkg;

    // playfield geometry: 128 columns by 48 rows of cell pairs
    localparam logic [7:0] FIELD_COLS = 8'd128;
    localparam logic [5:0] FIELD_ROWS = 6'd48;

    // tile map address, row number above the column
    localparam int TM_ADR_W = 13;
    typedef logic [TM_ADR_W-1:0] tm_adr_t;

    // one tile map byte
    // bits 1..0 upper cell, bits 3..2 lower cell, high nibble is scratch
    typedef logic [7:0] tm_byte_t;

    // columns from here up belong to the scoreboard
    localparam logic [6:0] SCORE_COL_FIRST = 7'd120;

    // clock cycles spent on each position
    localparam logic [2:0] PHASES = 3'd5;
    typedef logic [2:0] phase_t;

    // one opcode runs per pass over the tile map
    typedef enum logic [3:0] {
        OP_IDLE     = 4'd0,
        OP_DUMP     = 4'd1,
        OP_NEWGAME  = 4'd2,
        OP_NEWLEVEL = 4'd3,
        OP_BOOT     = 4'd7
    } opcode_t;

    // contents of one play area cell
    typedef enum logic [1:0] {
        CELL_EMPTY  = 2'd0,
        CELL_ROBOT  = 2'd1,
        CELL_TRASH  = 2'd2,
        CELL_PLAYER = 2'd3
    } cell_t;

    // robots added per 65536 cells at each level
    localparam logic [11:0] ROBOT_PROB_STEP = 12'd171;

    // player placement limits
    localparam logic [6:0] PLAYER_X_LIMIT = 7'd120;
    localparam logic [6:0] PLAYER_Y_BASE = 7'd16;

    // framing bytes of the serial dump
    localparam tm_byte_t DUMP_START = 8'd35;
    localparam tm_byte_t DUMP_ROW_START = 8'd36;
    localparam tm_byte_t DUMP_ROW_END = 8'd37;
    localparam tm_byte_t DUMP_END = 8'd38;

    localparam logic [28:0] PRNG_SEED = 29'd1;

endpackage
